//--- mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define NB_DATA    32
`define NB_REG     5
`define NB_IMM     32
`define NB_OP      6
`define NB_FN      6
`define NB_ALU_OP  4

`define OP_RTYPE   6'b000000
`define OP_J       6'b000010
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011
`define OP_HLT     6'b111111

`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010
`define FN_SLTU    6'b101011

`define ALU_ADD    4'd0
`define ALU_SUB    4'd1
`define ALU_AND    4'd2
`define ALU_OR     4'd3
`define ALU_XOR    4'd4
`define ALU_NOR    4'd5
`define ALU_SLT    4'd6
`define ALU_SLTU   4'd7
`define ALU_SLL    4'd8
`define ALU_SRL    4'd9
`define ALU_SRA    4'd10
`define ALU_LUI    4'd11

`endif

//--- mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

    typedef enum logic [`NB_ALU_OP-1:0] {
        alu_add  = `ALU_ADD,
        alu_sub  = `ALU_SUB,
        alu_and  = `ALU_AND,
        alu_or   = `ALU_OR,
        alu_xor  = `ALU_XOR,
        alu_nor  = `ALU_NOR,
        alu_slt  = `ALU_SLT,
        alu_sltu = `ALU_SLTU,
        alu_sll  = `ALU_SLL,
        alu_srl  = `ALU_SRL,
        alu_sra  = `ALU_SRA,
        alu_lui  = `ALU_LUI
    } alu_op_t;

    typedef struct packed {
        logic                reg_write;
        logic                mem_to_reg;
        logic                mem_read;
        logic                mem_write;
        logic                branch;
        logic                branch_ne;   // set together with branch for bne.
        logic                alu_src;
        logic                reg_dest;
        logic                signed_flag;
        logic                byte_en;
        logic                halfword_en;
        logic                word_en;
        logic                hlt;
        logic                jump;
        alu_op_t             alu_op;
        logic [`NB_DATA-1:0] pc;
        logic [`NB_DATA-1:0] data_a;
        logic [`NB_DATA-1:0] data_b;
        logic [`NB_IMM-1:0]  immediate;
        logic [`NB_DATA-1:0] shamt;
        logic [`NB_REG-1:0]  rs;
        logic [`NB_REG-1:0]  rt;
        logic [`NB_REG-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic                reg_write;
        logic                mem_to_reg;
        logic                mem_read;
        logic                mem_write;
        logic                signed_flag;
        logic                byte_en;
        logic                halfword_en;
        logic                word_en;
        logic                hlt;
        logic                pc_redirect;
        logic [`NB_DATA-1:0] alu_result;   // also the memory address.
        logic [`NB_DATA-1:0] store_data;
        logic [`NB_DATA-1:0] redirect_target;
        logic [`NB_REG-1:0]  write_reg;
    } ex_mem_t;

endpackage

//--- instr_decoder.sv
`include "mips_consts.svh"

module instr_decoder (
    input  logic [`NB_DATA-1:0] instr,
    input  logic [`NB_DATA-1:0] pc,
    input  logic [`NB_DATA-1:0] data_a,
    input  logic [`NB_DATA-1:0] data_b,
    output mips_pkg::id_ex_t    id_ex
);

    logic [`NB_OP-1:0]  opcode;
    logic [`NB_FN-1:0]  funct;
    logic [15:0]        imm16;
    logic [`NB_IMM-1:0] imm_sext;
    logic [`NB_IMM-1:0] imm_zext;
    logic               known;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign imm16    = instr[15:0];
    assign imm_sext = {{(`NB_IMM-16){imm16[15]}}, imm16};
    assign imm_zext = {{(`NB_IMM-16){1'b0}}, imm16};

    always_comb begin
        known              = 1'b1;
        id_ex              = '0;
        id_ex.pc           = pc;
        id_ex.data_a       = data_a;
        id_ex.data_b       = data_b;
        id_ex.rs           = instr[25:21];
        id_ex.rt           = instr[20:16];
        id_ex.rd           = instr[15:11];
        id_ex.shamt        = {{(`NB_DATA-5){1'b0}}, instr[10:6]};
        id_ex.immediate    = imm_sext;   // most encodings sign-extend.
        case (opcode)
            `OP_RTYPE: begin
                id_ex.reg_write = 1'b1;
                id_ex.reg_dest  = 1'b1;
                case (funct)
                    `FN_ADD, `FN_ADDU: id_ex.alu_op = mips_pkg::alu_add;
                    `FN_SUB, `FN_SUBU: id_ex.alu_op = mips_pkg::alu_sub;
                    `FN_AND:           id_ex.alu_op = mips_pkg::alu_and;
                    `FN_OR:            id_ex.alu_op = mips_pkg::alu_or;
                    `FN_XOR:           id_ex.alu_op = mips_pkg::alu_xor;
                    `FN_NOR:           id_ex.alu_op = mips_pkg::alu_nor;
                    `FN_SLT:           id_ex.alu_op = mips_pkg::alu_slt;
                    `FN_SLTU:          id_ex.alu_op = mips_pkg::alu_sltu;
                    `FN_SLL:           id_ex.alu_op = mips_pkg::alu_sll;
                    `FN_SRL:           id_ex.alu_op = mips_pkg::alu_srl;
                    `FN_SRA:           id_ex.alu_op = mips_pkg::alu_sra;
                    default:           known = 1'b0;
                endcase
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_src   = 1'b1;
                if (opcode == `OP_SLTI) begin
                    id_ex.alu_op = mips_pkg::alu_slt;
                end else if (opcode == `OP_SLTIU) begin
                    id_ex.alu_op = mips_pkg::alu_sltu;   // compared unsigned after sign extension.
                end else begin
                    id_ex.alu_op = mips_pkg::alu_add;
                end
            end
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_src   = 1'b1;
                id_ex.immediate = imm_zext;
                if (opcode == `OP_ANDI) begin
                    id_ex.alu_op = mips_pkg::alu_and;
                end else if (opcode == `OP_ORI) begin
                    id_ex.alu_op = mips_pkg::alu_or;
                end else begin
                    id_ex.alu_op = mips_pkg::alu_xor;
                end
            end
            `OP_LUI: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_src   = 1'b1;
                id_ex.alu_op    = mips_pkg::alu_lui;
                id_ex.immediate = {imm16, 16'b0};
            end
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                id_ex.reg_write   = 1'b1;
                id_ex.mem_to_reg  = 1'b1;
                id_ex.mem_read    = 1'b1;
                id_ex.alu_src     = 1'b1;
                id_ex.alu_op      = mips_pkg::alu_add;
                id_ex.byte_en     = (opcode == `OP_LB) || (opcode == `OP_LBU);
                id_ex.halfword_en = (opcode == `OP_LH) || (opcode == `OP_LHU);
                id_ex.word_en     = (opcode == `OP_LW);
                id_ex.signed_flag = (opcode == `OP_LB) || (opcode == `OP_LH);
            end
            `OP_SB, `OP_SH, `OP_SW: begin
                id_ex.mem_write   = 1'b1;
                id_ex.alu_src     = 1'b1;
                id_ex.alu_op      = mips_pkg::alu_add;
                id_ex.byte_en     = (opcode == `OP_SB);
                id_ex.halfword_en = (opcode == `OP_SH);
                id_ex.word_en     = (opcode == `OP_SW);
            end
            `OP_BEQ, `OP_BNE: begin
                id_ex.branch    = 1'b1;
                id_ex.branch_ne = (opcode == `OP_BNE);
                id_ex.alu_op    = mips_pkg::alu_sub;
            end
            `OP_J: begin
                id_ex.jump      = 1'b1;
                id_ex.immediate = {6'b0, instr[25:0]};   // the 26-bit instruction index.
            end
            `OP_HLT: id_ex.hlt = 1'b1;
            default: known = 1'b0;
        endcase
        // an unknown encoding becomes a bubble that still carries pc and operands.
        if (!known) begin
            id_ex        = '0;
            id_ex.pc     = pc;
            id_ex.data_a = data_a;
            id_ex.data_b = data_b;
        end
    end

endmodule

//--- pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clock,
    input  logic     i_reset,
    input  logic     i_pipeline_enable,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            q <= '0;
        end else if (i_pipeline_enable) begin
            q <= d;
        end
    end

    // a stall freezes the stage no matter what the upstream logic presents.
    a_hold_on_stall: assert property (@(posedge i_clock)
        !i_reset && !i_pipeline_enable |=> $stable(q));

    a_zero_after_reset: assert property (@(posedge i_clock)
        i_reset |=> q == '0);   // the stage comes out of reset as a bubble.

endmodule

//--- execute_stage.sv
`include "mips_consts.svh"

module execute_stage (
    input  mips_pkg::id_ex_t  id_ex,
    output mips_pkg::ex_mem_t ex_mem
);

    logic [`NB_DATA-1:0] op_b;
    logic [`NB_DATA-1:0] alu_result;
    logic [`NB_DATA-1:0] pc_plus4;
    logic [`NB_DATA-1:0] branch_target;
    logic [`NB_DATA-1:0] jump_target;
    logic                operands_equal;
    logic                branch_taken;
    logic                write_enable;

    assign op_b = id_ex.alu_src ? id_ex.immediate : id_ex.data_b;

    // shifts take the value from data_b and the amount from shamt.
    always_comb begin
        case (id_ex.alu_op)
            mips_pkg::alu_add:  alu_result = id_ex.data_a + op_b;
            mips_pkg::alu_sub:  alu_result = id_ex.data_a - op_b;
            mips_pkg::alu_and:  alu_result = id_ex.data_a & op_b;
            mips_pkg::alu_or:   alu_result = id_ex.data_a | op_b;
            mips_pkg::alu_xor:  alu_result = id_ex.data_a ^ op_b;
            mips_pkg::alu_nor:  alu_result = ~(id_ex.data_a | op_b);
            mips_pkg::alu_slt:
                alu_result = {{(`NB_DATA-1){1'b0}}, ($signed(id_ex.data_a) < $signed(op_b))};
            mips_pkg::alu_sltu:
                alu_result = {{(`NB_DATA-1){1'b0}}, (id_ex.data_a < op_b)};
            mips_pkg::alu_sll:  alu_result = op_b << id_ex.shamt[4:0];
            mips_pkg::alu_srl:  alu_result = op_b >> id_ex.shamt[4:0];
            mips_pkg::alu_sra:  alu_result = $signed(op_b) >>> id_ex.shamt[4:0];
            mips_pkg::alu_lui:  alu_result = op_b;   // the decoder already shifted it up.
            default:            alu_result = '0;
        endcase
    end

    assign pc_plus4       = id_ex.pc + `NB_DATA'd4;
    assign branch_target  = pc_plus4 + {id_ex.immediate[`NB_IMM-3:0], 2'b00};
    assign jump_target    = {pc_plus4[31:28], id_ex.immediate[25:0], 2'b00};
    assign operands_equal = (id_ex.data_a == id_ex.data_b);
    assign branch_taken   = id_ex.branch && (id_ex.branch_ne ? !operands_equal : operands_equal);
    assign write_enable   = id_ex.reg_write && !id_ex.hlt;   // halt never writes back.

    always_comb begin
        ex_mem.reg_write       = write_enable;
        ex_mem.mem_to_reg      = id_ex.mem_to_reg;
        ex_mem.mem_read        = id_ex.mem_read && !id_ex.hlt;
        ex_mem.mem_write       = id_ex.mem_write && !id_ex.hlt;
        ex_mem.signed_flag     = id_ex.signed_flag;
        ex_mem.byte_en         = id_ex.byte_en;
        ex_mem.halfword_en     = id_ex.halfword_en;
        ex_mem.word_en         = id_ex.word_en;
        ex_mem.hlt             = id_ex.hlt;
        ex_mem.pc_redirect     = branch_taken || id_ex.jump;
        ex_mem.alu_result      = alu_result;
        ex_mem.store_data      = id_ex.data_b;
        ex_mem.redirect_target = id_ex.jump ? jump_target : branch_target;
        ex_mem.write_reg       = write_enable ? (id_ex.reg_dest ? id_ex.rd : id_ex.rt) : '0;
    end

    // the decoder picks one access size, and the ID/EX register must keep it that way.
    always_comb begin
        if (!$isunknown({id_ex.byte_en, id_ex.halfword_en, id_ex.word_en})) begin
            a_one_size: assert ($onehot0({id_ex.byte_en, id_ex.halfword_en, id_ex.word_en}))
                else $error("more than one memory access size enabled");
        end
    end

endmodule

//--- id_ex_top.sv
`include "mips_consts.svh"

module id_ex_top (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_pipeline_enable,
    input  logic [`NB_DATA-1:0] instr,
    input  logic [`NB_DATA-1:0] pc,
    input  logic [`NB_DATA-1:0] data_a,
    input  logic [`NB_DATA-1:0] data_b,
    output mips_pkg::ex_mem_t   ex_mem
);

    mips_pkg::id_ex_t  id_bundle;   // decoder output.
    mips_pkg::id_ex_t  ex_bundle;   // ID/EX register output.
    mips_pkg::ex_mem_t ex_result;

    instr_decoder u_decoder (
        .instr  (instr),
        .pc     (pc),
        .data_a (data_a),
        .data_b (data_b),
        .id_ex  (id_bundle)
    );

    pipe_reg #(
        .payload_t (mips_pkg::id_ex_t)
    ) u_id_ex_reg (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_pipeline_enable (i_pipeline_enable),
        .d                 (id_bundle),
        .q                 (ex_bundle)
    );

    execute_stage u_execute (
        .id_ex  (ex_bundle),
        .ex_mem (ex_result)
    );

    // both registers share the enable, so a stall freezes the whole slice.
    pipe_reg #(
        .payload_t (mips_pkg::ex_mem_t)
    ) u_ex_mem_reg (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_pipeline_enable (i_pipeline_enable),
        .d                 (ex_result),
        .q                 (ex_mem)
    );

endmodule

//--- tb_id_ex_top.sv
`include "mips_consts.svh"

module tb_id_ex_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES   = 600;
    localparam int HALT_TIMEOUT = 20;
    localparam logic [31:0] HALT_TAG = 32'h4a17_c3e5;
    localparam logic [2:0] CLS_NONE = 3'd0, CLS_R = 3'd1, CLS_I = 3'd2, CLS_MEM = 3'd3,
                           CLS_BR = 3'd4, CLS_HLT = 3'd5, CLS_BAD = 3'd6;

    typedef struct packed {
        logic [2:0]        cls;   // instruction class, which picks the checks.
        mips_pkg::ex_mem_t e;
    } expect_t;

    logic                i_clock;
    logic                i_reset;
    logic                i_pipeline_enable;
    logic [`NB_DATA-1:0] instr;
    logic [`NB_DATA-1:0] pc;
    logic [`NB_DATA-1:0] data_a;
    logic [`NB_DATA-1:0] data_b;
    mips_pkg::ex_mem_t   ex_mem;
    expect_t             exp_q1;
    expect_t             exp_q2;
    logic                primed;   // set once a reset edge has cleared both stages.
    logic [31:0]         lfsr_state;
    int                  failures;
    int                  mismatches;
    int                  timeouts;

    logic [5:0] fn_table [0:12] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
        `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA};
    // the last entry is an unused opcode.
    logic [5:0] op_table [0:20] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI,
        `OP_ORI, `OP_XORI, `OP_LUI, `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB,
        `OP_SH, `OP_SW, `OP_BEQ, `OP_BNE, `OP_J, `OP_HLT, 6'b010011};

    id_ex_top dut (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_pipeline_enable (i_pipeline_enable),
        .instr             (instr),
        .pc                (pc),
        .data_a            (data_a),
        .data_b            (data_b),
        .ex_mem            (ex_mem)
    );

    always #10 i_clock = ~i_clock;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [9:0] ctrl_of(input mips_pkg::ex_mem_t e);
        return {e.reg_write, e.mem_to_reg, e.mem_read, e.mem_write, e.signed_flag,
                e.byte_en, e.halfword_en, e.word_en, e.hlt, e.pc_redirect};
    endfunction

    function automatic expect_t expect_of(input logic [31:0] ins, input logic [31:0] pc_in,
                                          input logic [31:0] a, input logic [31:0] b);
        expect_t     x;
        logic [5:0]  op;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] pc4;
        op            = ins[31:26];
        se            = {{16{ins[15]}}, ins[15:0]};
        ze            = {16'h0000, ins[15:0]};
        pc4           = pc_in + 32'd4;
        x             = '0;
        x.cls         = CLS_I;
        x.e.reg_write = 1'b1;   // most encodings write rt back.
        x.e.write_reg = ins[20:16];
        case (op)
            `OP_RTYPE: begin
                x.cls         = CLS_R;
                x.e.write_reg = ins[15:11];
                case (ins[5:0])
                    `FN_ADD, `FN_ADDU: x.e.alu_result = a + b;
                    `FN_SUB, `FN_SUBU: x.e.alu_result = a - b;
                    `FN_AND:  x.e.alu_result = a & b;
                    `FN_OR:   x.e.alu_result = a | b;
                    `FN_XOR:  x.e.alu_result = a ^ b;
                    `FN_NOR:  x.e.alu_result = ~(a | b);
                    `FN_SLT:  x.e.alu_result = {31'b0, $signed(a) < $signed(b)};
                    `FN_SLTU: x.e.alu_result = {31'b0, a < b};
                    `FN_SLL:  x.e.alu_result = b << ins[10:6];
                    `FN_SRL:  x.e.alu_result = b >> ins[10:6];
                    `FN_SRA:  x.e.alu_result = $signed(b) >>> ins[10:6];
                    default:  x.cls = CLS_BAD;
                endcase
            end
            `OP_ADDI, `OP_ADDIU: x.e.alu_result = a + se;
            `OP_SLTI:  x.e.alu_result = {31'b0, $signed(a) < $signed(se)};
            `OP_SLTIU: x.e.alu_result = {31'b0, a < se};
            `OP_ANDI:  x.e.alu_result = a & ze;
            `OP_ORI:   x.e.alu_result = a | ze;
            `OP_XORI:  x.e.alu_result = a ^ ze;
            `OP_LUI:   x.e.alu_result = {ins[15:0], 16'h0000};
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW: begin
                x.cls           = CLS_MEM;
                x.e.alu_result  = a + se;
                x.e.mem_read    = !op[3];   // stores are the opcodes with bit 3 set.
                x.e.mem_to_reg  = !op[3];
                x.e.mem_write   = op[3];
                x.e.reg_write   = !op[3];
                x.e.write_reg   = op[3] ? 5'd0 : ins[20:16];
                x.e.byte_en     = op[1:0] == 2'b00;
                x.e.halfword_en = op[1:0] == 2'b01;
                x.e.word_en     = op[1:0] == 2'b11;
                x.e.signed_flag = op == `OP_LB || op == `OP_LH;
            end
            `OP_BEQ, `OP_BNE, `OP_J: begin
                x.cls               = CLS_BR;
                x.e.reg_write       = 1'b0;
                x.e.write_reg       = '0;
                x.e.pc_redirect     = op == `OP_J || ((a == b) == (op == `OP_BEQ));
                x.e.redirect_target = op == `OP_J ? {pc4[31:28], ins[25:0], 2'b00}
                                                  : pc4 + {se[29:0], 2'b00};
            end
            `OP_HLT: x.cls = CLS_HLT;
            default: x.cls = CLS_BAD;
        endcase
        if (x.cls == CLS_HLT || x.cls == CLS_BAD) begin
            x.e = '0;   // neither a halt nor a bubble writes anything.
        end
        x.e.hlt        = x.cls == CLS_HLT;
        x.e.store_data = b;
        return x;
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // the result fields are compared only for classes that define them.
    task automatic show_fields(input expect_t want, input mips_pkg::ex_mem_t got);
        failures++;
        note_mismatch("control", ctrl_of(got), ctrl_of(want.e));
        note_mismatch("write_reg", got.write_reg, want.e.write_reg);
        note_mismatch("store_data", got.store_data, want.e.store_data);
        if (want.cls == CLS_R || want.cls == CLS_I || want.cls == CLS_MEM) begin
            note_mismatch("alu_result", got.alu_result, want.e.alu_result);
        end
        if (want.e.pc_redirect) begin
            note_mismatch("redirect_target", got.redirect_target, want.e.redirect_target);
        end
    endtask

    task automatic drive_random();
        int          idx;
        logic [31:0] fields;
        logic [31:0] a;
        idx = int'(lfsr_take(6) % 34);
        if (idx < 13) begin
            fields = lfsr_take(20);   // rs, rt, rd and shamt.
            instr  <= {`OP_RTYPE, fields[19:0], fn_table[idx]};
        end else begin
            fields = lfsr_take(26);
            instr  <= {op_table[idx-13], fields[25:0]};
        end
        a = lfsr_take(32);
        pc     <= lfsr_take(32);
        data_a <= a;
        data_b <= lfsr_take(1) ? a : lfsr_take(32);   // equal operands make branches taken.
        i_pipeline_enable <= lfsr_take(2) != 32'd0;
    endtask

    // the expected results move through two stages, as the DUT's registers do.
    always @(posedge i_clock) begin
        if (i_reset) begin
            exp_q1 <= '0;
            exp_q2 <= '0;
            primed <= 1'b1;
        end else if (i_pipeline_enable) begin
            exp_q1 <= expect_of(instr, pc, data_a, data_b);
            exp_q2 <= exp_q1;
        end
    end

    a_arith: assert property (@(posedge i_clock)
        primed && (exp_q2.cls == CLS_R || exp_q2.cls == CLS_I)
        |-> ex_mem.alu_result == exp_q2.e.alu_result && ex_mem.write_reg == exp_q2.e.write_reg)
        else show_fields($sampled(exp_q2), $sampled(ex_mem));

    a_memory: assert property (@(posedge i_clock) primed && exp_q2.cls == CLS_MEM
        |-> ex_mem.alu_result == exp_q2.e.alu_result && ex_mem.store_data == exp_q2.e.store_data
            && ex_mem.write_reg == exp_q2.e.write_reg && ctrl_of(ex_mem) == ctrl_of(exp_q2.e))
        else show_fields($sampled(exp_q2), $sampled(ex_mem));

    a_redirect: assert property (@(posedge i_clock) primed && exp_q2.cls == CLS_BR
        |-> ex_mem.pc_redirect == exp_q2.e.pc_redirect
            && (!exp_q2.e.pc_redirect || ex_mem.redirect_target == exp_q2.e.redirect_target))
        else show_fields($sampled(exp_q2), $sampled(ex_mem));

    a_bubble: assert property (@(posedge i_clock)
        primed && (exp_q2.cls == CLS_NONE || exp_q2.cls == CLS_BAD) |-> ctrl_of(ex_mem) == '0)
        else show_fields($sampled(exp_q2), $sampled(ex_mem));

    a_halt: assert property (@(posedge i_clock) primed && exp_q2.cls == CLS_HLT
        |-> ex_mem.hlt && !ex_mem.reg_write && !ex_mem.mem_read && !ex_mem.mem_write)
        else show_fields($sampled(exp_q2), $sampled(ex_mem));

    a_stall_holds: assert property (@(posedge i_clock)
        primed && !i_reset && !i_pipeline_enable |=> $stable(ex_mem))
        else begin
            failures++;
            $display("ex_mem changed at %0t although the pipeline enable was low", $time);
        end

    initial begin
        int   cycles;
        logic seen;
        lfsr_state        = 32'h0641_7aa1;
        failures          = 0;
        mismatches        = 0;
        timeouts          = 0;
        primed            = 1'b0;
        i_clock           = 1'b0;
        i_reset           = 1'b1;
        i_pipeline_enable = 1'b0;
        instr             = '0;
        pc                = '0;
        data_a            = '0;
        data_b            = '0;
        repeat (8) @(posedge i_clock);
        i_reset <= 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random();
            @(posedge i_clock);
        end
        // a final halt shows that the slice still drains after the random run.
        instr             <= {`OP_HLT, 26'h0};
        data_b            <= HALT_TAG;   // tells this halt apart from a random one still in flight.
        i_pipeline_enable <= 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < HALT_TIMEOUT) begin
            @(negedge i_clock);
            seen = ex_mem.hlt && ex_mem.store_data == HALT_TAG;
            cycles++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no halt reached ex_mem within %0d cycles", HALT_TIMEOUT);
        end
        @(negedge i_clock);
        $display("checks failed: %0d, field mismatches: %0d, timeouts: %0d",
                 failures, mismatches, timeouts);
        if (failures == 0 && mismatches == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
mips_pkg.sv
instr_decoder.sv
pipe_reg.sv
execute_stage.sv
id_ex_top.sv
tb_id_ex_top.sv
